// ==== source/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // Peripheral slot map
    localparam int SLOT_GPIO  = 0;
    localparam int SLOT_TIMER = 1;
    localparam int SLOT_IRQ   = 2;
    localparam int SLOT_PNP   = 3;
    localparam int SLOT_TOTAL = 4;
    localparam int SLOT_SEL_W = $clog2(SLOT_TOTAL);  // Bits to pick a fitted slot

    typedef struct packed {
        logic        valid;                          // One-cycle request strobe
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        valid;
        logic        err;                            // Unfitted slot or unknown index
        logic [31:0] rdata;
    } bus_resp_t;

    // Address layout, slot in the top nibble
    typedef struct packed {
        logic [3:0] slot;
        logic [9:0] index;
        logic [1:0] offset;
    } bus_addr_t;

    typedef union packed {
        logic [15:0] raw;
        bus_addr_t   field;
    } bus_addr_u;

    typedef bus_req_t  [SLOT_TOTAL-1:0] bus_req_vec_t;
    typedef bus_resp_t [SLOT_TOTAL-1:0] bus_resp_vec_t;

endpackage

`default_nettype wire

// ==== source/soc_cfg_pkg.sv ====
`default_nettype none

package soc_cfg_pkg;

    localparam logic [31:0] SOC_HW_ID = 32'h5A0C_0001;
    localparam logic [15:0] VENDOR_ID = 16'h00F1;

    // Device codes reported by the PNP table
    localparam logic [7:0] DEV_ID_GPIO  = 8'h11;
    localparam logic [7:0] DEV_ID_TIMER = 8'h12;
    localparam logic [7:0] DEV_ID_IRQ   = 8'h13;
    localparam logic [7:0] DEV_ID_PNP   = 8'h14;

    localparam int GPIO_WIDTH = 8;

    // Interrupt sources; source 0 means no interrupt
    localparam int IRQ_TOTAL     = 16;
    localparam int IRQ_ID_W      = $clog2(IRQ_TOTAL);
    localparam int IRQ_GPIO_BASE = 1;                // Pin n maps to source n+1

    localparam logic [31:0] TIMER_CMP_RESET = '1;    // Keeps mtip low out of reset

    typedef struct packed {
        logic [15:0] vendor;
        logic [7:0]  device;
        logic [7:0]  slot;
    } dev_descr_t;

    typedef union packed {
        logic [31:0] raw;
        dev_descr_t  field;
    } dev_descr_u;

endpackage

`default_nettype wire

// ==== source/apb_slot_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_slot_decoder
(
    input  logic                       i_sys_clk,
    input  logic                       i_arst_n,
    input  soc_bus_pkg::bus_req_t      i_req,
    output soc_bus_pkg::bus_resp_t     o_resp,
    output soc_bus_pkg::bus_req_vec_t  o_slot_req,
    input  soc_bus_pkg::bus_resp_vec_t i_slot_resp
);
    import soc_bus_pkg::*;

    bus_addr_u             w_addr;
    logic                  w_fitted;
    logic                  r_valid;                  // Request seen last cycle
    logic                  r_fitted;
    logic [SLOT_SEL_W-1:0] r_sel;

    // Strobe goes only to the addressed slot
    always_comb
    begin
        w_addr.raw = i_req.addr;
        w_fitted = (w_addr.field.slot < 4'(SLOT_TOTAL));
        for (int s = 0; s < SLOT_TOTAL; s++)
        begin
            o_slot_req[s] = i_req;
            o_slot_req[s].valid = i_req.valid && w_fitted
                                  && (w_addr.field.slot == 4'(s));
        end
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_valid <= 1'b0;
            r_fitted <= 1'b0;
            r_sel <= '0;
        end
        else
        begin
            r_valid <= i_req.valid;
            if (i_req.valid)
            begin
                r_fitted <= w_fitted;
                r_sel <= w_addr.field.slot[SLOT_SEL_W-1:0];
            end
        end
    end

    // Slot answer, or our own error for an empty slot
    always_comb
    begin
        if (r_fitted)
        begin
            o_resp = i_slot_resp[r_sel];
        end
        else
        begin
            o_resp.valid = r_valid;
            o_resp.err = r_valid;
            o_resp.rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/apb_gpio.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_gpio
(
    input  logic                               i_sys_clk,
    input  logic                               i_arst_n,
    input  soc_bus_pkg::bus_req_t              i_req,
    output soc_bus_pkg::bus_resp_t             o_resp,
    input  logic [soc_cfg_pkg::GPIO_WIDTH-1:0] i_gpio,
    output logic [soc_cfg_pkg::GPIO_WIDTH-1:0] o_gpio,
    output logic [soc_cfg_pkg::GPIO_WIDTH-1:0] o_gpio_dir,
    output logic [soc_cfg_pkg::GPIO_WIDTH-1:0] o_irq
);
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    bus_addr_u             w_addr;
    logic                  w_wr;
    logic                  w_err;
    logic [31:0]           w_rdata;
    logic [GPIO_WIDTH-1:0] r_sync1;
    logic [GPIO_WIDTH-1:0] r_sync2;                  // Safe to use from here on
    logic [GPIO_WIDTH-1:0] r_out;
    logic [GPIO_WIDTH-1:0] r_dir;
    logic [GPIO_WIDTH-1:0] r_ie;
    bus_resp_t             r_resp;

    always_comb
    begin
        w_addr.raw = i_req.addr;
        w_wr = i_req.valid && i_req.write;
        w_err = 1'b0;
        w_rdata = '0;
        case (w_addr.field.index)
            10'd0: w_rdata = 32'(r_sync2);           // Input, writes dropped
            10'd1: w_rdata = 32'(r_out);
            10'd2: w_rdata = 32'(r_dir);
            10'd3: w_rdata = 32'(r_ie);
            default: w_err = 1'b1;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_sync1 <= '0;
            r_sync2 <= '0;
            r_out <= '0;
            r_dir <= '0;
            r_ie <= '0;
            r_resp <= '0;
        end
        else
        begin
            r_sync1 <= i_gpio;
            r_sync2 <= r_sync1;
            if (w_wr && w_addr.field.index == 10'd1)
                r_out <= i_req.wdata[GPIO_WIDTH-1:0];
            if (w_wr && w_addr.field.index == 10'd2)
                r_dir <= i_req.wdata[GPIO_WIDTH-1:0];
            if (w_wr && w_addr.field.index == 10'd3)
                r_ie <= i_req.wdata[GPIO_WIDTH-1:0];
            r_resp.valid <= i_req.valid;
            r_resp.err <= i_req.valid && w_err;
            r_resp.rdata <= w_rdata;
        end
    end

    assign o_resp = r_resp;
    assign o_gpio = r_out;
    assign o_gpio_dir = r_dir;
    assign o_irq = r_sync2 & r_ie;                   // Level interrupt per pin

endmodule

`default_nettype wire

// ==== source/soc_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module soc_timer
(
    input  logic                   i_sys_clk,
    input  logic                   i_arst_n,
    input  soc_bus_pkg::bus_req_t  i_req,
    output soc_bus_pkg::bus_resp_t o_resp,
    output logic                   o_mtip
);
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    bus_addr_u   w_addr;
    logic        w_wr;
    logic        w_err;
    logic [31:0] w_rdata;
    logic [31:0] w_mtime_next;
    logic [31:0] w_cmp_next;
    logic [31:0] r_mtime;
    logic [31:0] r_mtimecmp;
    logic        r_mtip;
    bus_resp_t   r_resp;

    always_comb
    begin
        w_addr.raw = i_req.addr;
        w_wr = i_req.valid && i_req.write;
        w_mtime_next = r_mtime + 32'd1;              // Free running
        w_cmp_next = r_mtimecmp;
        w_err = 1'b0;
        w_rdata = '0;
        case (w_addr.field.index)
            10'd0:
            begin
                w_rdata = r_mtime;
                if (w_wr)
                    w_mtime_next = i_req.wdata;
            end
            10'd1:
            begin
                w_rdata = r_mtimecmp;
                if (w_wr)
                    w_cmp_next = i_req.wdata;
            end
            default: w_err = 1'b1;
        endcase
    end

    // Compare the next values so mtip tracks a write in the same cycle
    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_mtime <= '0;
            r_mtimecmp <= TIMER_CMP_RESET;
            r_mtip <= 1'b0;
            r_resp <= '0;
        end
        else
        begin
            r_mtime <= w_mtime_next;
            r_mtimecmp <= w_cmp_next;
            r_mtip <= (w_mtime_next >= w_cmp_next);
            r_resp.valid <= i_req.valid;
            r_resp.err <= i_req.valid && w_err;
            r_resp.rdata <= w_rdata;
        end
    end

    assign o_resp = r_resp;
    assign o_mtip = r_mtip;

endmodule

`default_nettype wire

// ==== source/irq_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module irq_ctrl
(
    input  logic                              i_sys_clk,
    input  logic                              i_arst_n,
    input  soc_bus_pkg::bus_req_t             i_req,
    output soc_bus_pkg::bus_resp_t            o_resp,
    input  logic [soc_cfg_pkg::IRQ_TOTAL-1:0] i_irq_src,
    output logic                              o_meip
);
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    bus_addr_u            w_addr;
    logic                 w_err;
    logic [31:0]          w_rdata;
    logic [IRQ_ID_W-1:0]  w_claim_id;
    logic [IRQ_TOTAL-1:0] w_claim_mask;              // Source taken by this read
    logic [IRQ_TOTAL-1:0] w_cpl_mask;
    logic [IRQ_TOTAL-1:0] r_pending;
    logic [IRQ_TOTAL-1:0] r_enable;
    logic [IRQ_TOTAL-1:0] r_inservice;
    logic                 r_meip;
    bus_resp_t            r_resp;

    always_comb
    begin
        w_addr.raw = i_req.addr;
        // Lowest enabled pending source wins, 0 when idle
        w_claim_id = '0;
        for (int i = IRQ_TOTAL - 1; i > 0; i--)
        begin
            if (r_pending[i] && r_enable[i])
                w_claim_id = IRQ_ID_W'(i);
        end
        w_claim_mask = '0;
        w_cpl_mask = '0;
        w_err = 1'b0;
        w_rdata = '0;
        case (w_addr.field.index)
            10'd0: w_rdata = 32'(r_pending);
            10'd1: w_rdata = 32'(r_enable);
            10'd2:
            begin
                w_rdata = 32'(w_claim_id);
                if (i_req.valid && !i_req.write && w_claim_id != '0)
                    w_claim_mask = IRQ_TOTAL'(1) << w_claim_id;
                if (i_req.valid && i_req.write)
                    w_cpl_mask = IRQ_TOTAL'(1) << i_req.wdata[IRQ_ID_W-1:0];
            end
            default: w_err = 1'b1;
        endcase
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_pending <= '0;
            r_enable <= '0;
            r_inservice <= '0;
            r_meip <= 1'b0;
            r_resp <= '0;
        end
        else
        begin
            r_pending <= (r_pending | (i_irq_src & ~r_inservice)) & ~w_claim_mask;
            r_inservice <= (r_inservice | w_claim_mask) & ~w_cpl_mask;
            if (i_req.valid && i_req.write && w_addr.field.index == 10'd1)
                r_enable <= i_req.wdata[IRQ_TOTAL-1:0];
            r_meip <= |(r_pending & r_enable);
            r_resp.valid <= i_req.valid;
            r_resp.err <= i_req.valid && w_err;
            r_resp.rdata <= w_rdata;
        end
    end

    assign o_resp = r_resp;
    assign o_meip = r_meip;

endmodule

`default_nettype wire

// ==== source/apb_pnp.sv ====
`timescale 1ns/1ns
`default_nettype none

module apb_pnp
(
    input  logic                   i_sys_clk,
    input  logic                   i_arst_n,
    input  soc_bus_pkg::bus_req_t  i_req,
    output soc_bus_pkg::bus_resp_t o_resp
);
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    bus_addr_u   w_addr;
    logic [9:0]  w_entry;                            // Descriptor number
    logic        w_err;
    logic [31:0] w_rdata;
    dev_descr_u  w_table [SLOT_TOTAL];
    bus_resp_t   r_resp;

    always_comb
    begin
        w_table[SLOT_GPIO].field = '{VENDOR_ID, DEV_ID_GPIO, 8'(SLOT_GPIO)};
        w_table[SLOT_TIMER].field = '{VENDOR_ID, DEV_ID_TIMER, 8'(SLOT_TIMER)};
        w_table[SLOT_IRQ].field = '{VENDOR_ID, DEV_ID_IRQ, 8'(SLOT_IRQ)};
        w_table[SLOT_PNP].field = '{VENDOR_ID, DEV_ID_PNP, 8'(SLOT_PNP)};
        w_addr.raw = i_req.addr;
        w_entry = w_addr.field.index - 10'd2;        // Wraps high for index 0 and 1
        w_err = i_req.write;                         // Table is read-only
        w_rdata = '0;
        if (w_addr.field.index == 10'd0)
            w_rdata = SOC_HW_ID;
        else if (w_addr.field.index == 10'd1)
            w_rdata = 32'(SLOT_TOTAL);
        else if (w_entry < 10'(SLOT_TOTAL))
            w_rdata = w_table[w_entry[SLOT_SEL_W-1:0]].raw;
        else
            w_err = 1'b1;
    end

    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_resp <= '0;
        else
        begin
            r_resp.valid <= i_req.valid;
            r_resp.err <= i_req.valid && w_err;
            r_resp.rdata <= w_err ? '0 : w_rdata;
        end
    end

    assign o_resp = r_resp;

endmodule

`default_nettype wire

// ==== source/periph_soc.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_soc
(
    input  logic                               i_sys_clk,
    input  logic                               i_arst_n,
    input  soc_bus_pkg::bus_req_t              i_req,
    output soc_bus_pkg::bus_resp_t             o_resp,
    input  logic [soc_cfg_pkg::GPIO_WIDTH-1:0] i_gpio,
    output logic [soc_cfg_pkg::GPIO_WIDTH-1:0] o_gpio,
    output logic [soc_cfg_pkg::GPIO_WIDTH-1:0] o_gpio_dir,
    output logic                               o_mtip,   // Machine timer interrupt
    output logic                               o_meip    // Machine external interrupt
);
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    bus_req_vec_t          w_slot_req;
    bus_resp_vec_t         w_slot_resp;
    logic [GPIO_WIDTH-1:0] w_gpio_irq;
    logic [IRQ_TOTAL-1:0]  w_irq_src;

    apb_slot_decoder decoder_inst (
        .i_sys_clk(i_sys_clk),
        .i_arst_n(i_arst_n),
        .i_req(i_req),
        .o_resp(o_resp),
        .o_slot_req(w_slot_req),
        .i_slot_resp(w_slot_resp)
    );

    apb_gpio gpio_inst (
        .i_sys_clk(i_sys_clk),
        .i_arst_n(i_arst_n),
        .i_req(w_slot_req[SLOT_GPIO]),
        .o_resp(w_slot_resp[SLOT_GPIO]),
        .i_gpio(i_gpio),
        .o_gpio(o_gpio),
        .o_gpio_dir(o_gpio_dir),
        .o_irq(w_gpio_irq)
    );

    soc_timer timer_inst (
        .i_sys_clk(i_sys_clk),
        .i_arst_n(i_arst_n),
        .i_req(w_slot_req[SLOT_TIMER]),
        .o_resp(w_slot_resp[SLOT_TIMER]),
        .o_mtip(o_mtip)
    );

    irq_ctrl irq_inst (
        .i_sys_clk(i_sys_clk),
        .i_arst_n(i_arst_n),
        .i_req(w_slot_req[SLOT_IRQ]),
        .o_resp(w_slot_resp[SLOT_IRQ]),
        .i_irq_src(w_irq_src),
        .o_meip(o_meip)
    );

    apb_pnp pnp_inst (
        .i_sys_clk(i_sys_clk),
        .i_arst_n(i_arst_n),
        .i_req(w_slot_req[SLOT_PNP]),
        .o_resp(w_slot_resp[SLOT_PNP])
    );

    // GPIO pins from source 1 up, the rest unused
    always_comb
    begin
        w_irq_src = '0;
        w_irq_src[IRQ_GPIO_BASE +: GPIO_WIDTH] = w_gpio_irq;
    end

endmodule

`default_nettype wire

// ==== tests/periph_soc_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_soc_properties
(
    input logic                               i_sys_clk,
    input logic                               i_arst_n,
    input soc_bus_pkg::bus_req_t              i_req,
    input soc_bus_pkg::bus_resp_t             i_resp,
    input logic [soc_cfg_pkg::GPIO_WIDTH-1:0] i_gpio,
    input logic                               i_meip
);
    import soc_cfg_pkg::*;

    int                    fail_count = 0;       // Read by the testbench at the end
    logic [GPIO_WIDTH-1:0] r_gpio_d;
    logic                  w_gpio_chg;

    always_ff @(posedge i_sys_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_gpio_d <= '0;
        else
            r_gpio_d <= i_gpio;
    end

    assign w_gpio_chg = (i_gpio != r_gpio_d);

    // Every request answered on the next cycle
    resp_follows_req: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
        i_resp.valid == $past(i_req.valid))
    else
    begin
        $error("response valid does not follow the request valid of the previous cycle");
        fail_count++;
    end

    no_resp_after_reset: assert property (@(posedge i_sys_clk)
        $rose(i_arst_n) |-> !i_resp.valid)
    else
    begin
        $error("response valid seen in the first cycle after reset");
        fail_count++;
    end

    // Enable write, ie write or complete, or a pin through the synchroniser
    meip_has_cause: assert property (@(posedge i_sys_clk) disable iff (!i_arst_n)
        $rose(i_meip) |-> $past(i_req.valid, 2) || $past(i_req.valid, 3)
                          || $past(w_gpio_chg, 4))
    else
    begin
        $error("external interrupt rose without a request or pin change before it");
        fail_count++;
    end

endmodule

bind periph_soc periph_soc_properties props_inst (
    .i_sys_clk(i_sys_clk),
    .i_arst_n(i_arst_n),
    .i_req(i_req),
    .i_resp(o_resp),
    .i_gpio(i_gpio),
    .i_meip(o_meip)
);

`default_nettype wire

// ==== tests/periph_soc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module periph_soc_tb;
    import soc_bus_pkg::*;
    import soc_cfg_pkg::*;

    localparam int RESP_TIMEOUT = 8;
    localparam int IRQ_TIMEOUT = 64;             // Cycles to wait for an interrupt line

    logic                  sys_clk;
    logic                  arst_n;
    bus_req_t              req;
    bus_resp_t             resp;
    logic [GPIO_WIDTH-1:0] gpio_in;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_dir;
    logic                  mtip;
    logic                  meip;
    int                    check_count;
    int                    error_count;
    int                    test_count;
    int                    test_errors;
    int                    total_errors;
    string                 current_test;

    periph_soc periph_soc_inst (
        .i_sys_clk(sys_clk),
        .i_arst_n(arst_n),
        .i_req(req),
        .o_resp(resp),
        .i_gpio(gpio_in),
        .o_gpio(gpio_out),
        .o_gpio_dir(gpio_dir),
        .o_mtip(mtip),
        .o_meip(meip)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #50 sys_clk = ~sys_clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic check_value(input string item, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp)
        else
        begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     current_test, item, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_errors = error_count;
    endtask

    task automatic finish_test();
        test_count++;
        $display("Test %s: %0d errors", current_test, error_count - test_errors);
    endtask

    // One request, then wait for its answer
    task automatic bus_access(input logic is_write, input int slot, input int index,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        bus_addr_u addr;
        int        waited;
        addr.field.slot = 4'(slot);
        addr.field.index = 10'(index);
        addr.field.offset = 2'd0;
        waited = 0;
        @(posedge sys_clk);
        req <= '{valid: 1'b1, write: is_write, addr: addr.raw, wdata: wdata};
        @(posedge sys_clk);
        req <= '0;
        @(negedge sys_clk);
        while (!resp.valid && waited < RESP_TIMEOUT)
        begin
            @(negedge sys_clk);
            waited++;
        end
        if (!resp.valid)
            report_failure($sformatf("No bus response in %s for slot %0d index %0d",
                                     current_test, slot, index));
        rdata = resp.rdata;
        err = resp.err;
    endtask

    task automatic expect_read(input string item, input int slot, input int index,
                               input logic [31:0] exp);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b0, slot, index, 32'd0, rdata, err);
        check_value({item, " error flag"}, 32'd0, 32'(err));
        check_value(item, exp, rdata);
    endtask

    task automatic expect_write(input string item, input int slot, input int index,
                                input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, slot, index, wdata, rdata, err);
        check_value({item, " error flag"}, 32'd0, 32'(err));
    endtask

    task automatic expect_error(input string item, input int slot, input int index,
                                input logic is_write);
        logic [31:0] rdata;
        logic        err;
        bus_access(is_write, slot, index, 32'hdead_beef, rdata, err);
        check_value({item, " error flag"}, 32'd1, 32'(err));
        check_value({item, " data"}, 32'd0, rdata);
    endtask

    task automatic wait_for_line(input logic use_meip, input logic level);
        int waited;
        waited = 0;
        while (((use_meip ? meip : mtip) !== level) && waited < IRQ_TIMEOUT)
        begin
            @(negedge sys_clk);
            waited++;
        end
        if ((use_meip ? meip : mtip) !== level)
            report_failure($sformatf("Timeout in %s: %s never went to %0b", current_test,
                                     use_meip ? "o_meip" : "o_mtip", level));
    endtask

    task automatic check_descriptor(input int slot, input logic [7:0] device);
        logic [31:0] rdata;
        logic        err;
        dev_descr_u  descr;
        bus_access(1'b0, SLOT_PNP, 2 + slot, 32'd0, rdata, err);
        descr.raw = rdata;
        check_value("descriptor error flag", 32'd0, 32'(err));
        check_value("descriptor vendor", 32'(VENDOR_ID), 32'(descr.field.vendor));
        check_value("descriptor device", 32'(device), 32'(descr.field.device));
        check_value("descriptor slot", 32'(slot), 32'(descr.field.slot));
    endtask

    task automatic run_error_test();
        start_test("error responses");
        for (int s = SLOT_TOTAL; s < 16; s++)
            expect_error($sformatf("empty slot %0d", s), s, 0, 1'b0);
        expect_error("gpio index 4", SLOT_GPIO, 4, 1'b0);
        expect_error("timer index 2", SLOT_TIMER, 2, 1'b0);
        expect_error("irq index 3", SLOT_IRQ, 3, 1'b0);
        expect_error("pnp index 6", SLOT_PNP, 6, 1'b0);
        expect_error("pnp write", SLOT_PNP, 0, 1'b1);      // Table is read-only
        finish_test();
    endtask

    task automatic run_gpio_test();
        logic [31:0] value;
        start_test("gpio");
        value = $urandom;
        expect_write("output write", SLOT_GPIO, 1, value);
        check_value("o_gpio", 32'(value[GPIO_WIDTH-1:0]), 32'(gpio_out));
        expect_read("output read", SLOT_GPIO, 1, 32'(value[GPIO_WIDTH-1:0]));
        value = $urandom;
        expect_write("direction write", SLOT_GPIO, 2, value);
        check_value("o_gpio_dir", 32'(value[GPIO_WIDTH-1:0]), 32'(gpio_dir));
        expect_read("direction read", SLOT_GPIO, 2, 32'(value[GPIO_WIDTH-1:0]));
        value = $urandom;
        @(posedge sys_clk);
        gpio_in <= value[GPIO_WIDTH-1:0];
        repeat (3) @(posedge sys_clk);                      // Through the synchroniser
        expect_read("input read", SLOT_GPIO, 0, 32'(value[GPIO_WIDTH-1:0]));
        finish_test();
    endtask

    task automatic run_timer_test();
        logic [31:0] base;
        start_test("timer");
        base = $urandom & 32'h7fff_ffff;                    // Clear of counter wrap
        expect_write("mtime load", SLOT_TIMER, 0, base);
        expect_write("mtimecmp load", SLOT_TIMER, 1, base + 32'd24);
        check_value("o_mtip before match", 32'd0, 32'(mtip));
        expect_read("mtimecmp read", SLOT_TIMER, 1, base + 32'd24);
        wait_for_line(1'b0, 1'b1);
        expect_write("mtimecmp park", SLOT_TIMER, 1, 32'hffff_ffff);
        check_value("o_mtip after park", 32'd0, 32'(mtip));
        finish_test();
    endtask

    task automatic run_irq_test();
        int pin;
        start_test("interrupt");
        pin = int'($urandom % GPIO_WIDTH);
        @(posedge sys_clk);
        gpio_in <= '0;
        expect_write("gpio irq enable", SLOT_GPIO, 3, 32'(1) << pin);
        expect_write("source enable", SLOT_IRQ, 1, 32'(1) << (pin + IRQ_GPIO_BASE));
        check_value("o_meip idle", 32'd0, 32'(meip));
        @(posedge sys_clk);
        gpio_in <= GPIO_WIDTH'(1) << pin;
        wait_for_line(1'b1, 1'b1);
        expect_read("claim", SLOT_IRQ, 2, 32'(pin + IRQ_GPIO_BASE));
        wait_for_line(1'b1, 1'b0);
        @(posedge sys_clk);
        gpio_in <= '0;
        repeat (3) @(posedge sys_clk);                      // Let the low level through
        expect_write("complete", SLOT_IRQ, 2, 32'(pin + IRQ_GPIO_BASE));
        expect_read("pending after complete", SLOT_IRQ, 0, 32'd0);
        check_value("o_meip after complete", 32'd0, 32'(meip));
        finish_test();
    endtask

    task automatic run_pnp_test();
        start_test("pnp table");
        expect_read("hardware id", SLOT_PNP, 0, SOC_HW_ID);
        expect_read("slot total", SLOT_PNP, 1, 32'(SLOT_TOTAL));
        check_descriptor(SLOT_GPIO, DEV_ID_GPIO);
        check_descriptor(SLOT_TIMER, DEV_ID_TIMER);
        check_descriptor(SLOT_IRQ, DEV_ID_IRQ);
        check_descriptor(SLOT_PNP, DEV_ID_PNP);
        finish_test();
    endtask

    initial
    begin
        void'($urandom(32'h6123_402f));
        check_count = 0;
        error_count = 0;
        test_count = 0;
        test_errors = 0;
        arst_n = 1'b0;
        req = '0;
        gpio_in = '0;
        repeat (3) @(posedge sys_clk);
        arst_n <= 1'b1;
        @(negedge sys_clk);
        start_test("reset");
        check_value("outputs", 32'd0, 32'({resp.valid, gpio_out, gpio_dir, mtip, meip}));
        finish_test();
        run_error_test();
        run_gpio_test();
        run_timer_test();
        run_irq_test();
        run_pnp_test();
        total_errors = error_count + periph_soc_inst.props_inst.fail_count;
        $display("Tests: %0d, checks: %0d, errors: %0d, property failures: %0d",
                 test_count, check_count, error_count,
                 periph_soc_inst.props_inst.fail_count);
        if (total_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== periph_soc.f ====
source/soc_bus_pkg.sv
source/soc_cfg_pkg.sv
source/apb_slot_decoder.sv
source/apb_gpio.sv
source/soc_timer.sv
source/irq_ctrl.sv
source/apb_pnp.sv
source/periph_soc.sv
tests/periph_soc_properties.sv
tests/periph_soc_tb.sv

// ==== Makefile ====
# Verilator flow for the peripheral subsystem
VERILATOR ?= verilator
FILE_LIST ?= periph_soc.f
TB_TOP    ?= periph_soc_tb
RTL_TOP   ?= periph_soc
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
LINT_ARGS ?= --lint-only
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_ARGS) $(VFLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_ARGS) $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o sim_$(TB_TOP)
	-$(BUILD_DIR)/sim_$(TB_TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
